/* Makefile */
# Verilator build and run of the sprite display testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_sprite_display --Mdir obj_dir
	@out="$$(./obj_dir/Vtb_sprite_display)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* sim.f */
+incdir+test
source/video_pkg.sv
source/regmap_pkg.sv
source/avalon_regs.sv
source/vga_timing.sv
source/object_scanner.sv
source/layer_mixer.sv
source/sprite_display_top.sv
test/tb_sprite_display.sv

/* source/avalon_regs.sv */
// avalon-mm slave with object table, palette, byte-lane writes and one-cycle readback
`default_nettype none
`timescale 1ns/1ps

module avalon_regs #(
	parameter int NUM_OBJECTS = 8,
	parameter int NUM_PALETTE = 8
) (
	input  wire                    CLK,
	input  wire                    RESET,
	input  wire regmap_pkg::avl_req_t avl,
	output logic [31:0]            readdata,
	output regmap_pkg::reg_word_u  objects [NUM_OBJECTS],
	output regmap_pkg::reg_word_u  palette [NUM_PALETTE]
);

	localparam int OBJ_IDX_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1;

	// decoded strobes
	logic                 wr_obj;
	logic                 wr_pal;
	logic                 rd_en;
	logic [OBJ_IDX_W-1:0] obj_idx;
	logic [2:0]           pal_idx;
	logic [31:0]          rd_word;

	// replace only the lanes with their enable set
	function automatic logic [31:0] merge_lanes(
		input logic [31:0] old_word,
		input logic [31:0] new_word,
		input logic [3:0]  byte_en
	);
		logic [31:0] merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (byte_en[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// ==============================
	// address decode
	// ==============================

	// object index wraps on table size
	assign obj_idx = OBJ_IDX_W'(avl.addr % NUM_OBJECTS);
	// palette only looks at the low 3 bits
	assign pal_idx = avl.addr[2:0];

	assign wr_obj = avl.cs & avl.write & ~avl.addr[regmap_pkg::ADDR_SEL_BIT];
	assign wr_pal = avl.cs & avl.write & avl.addr[regmap_pkg::ADDR_SEL_BIT];
	assign rd_en  = avl.cs & avl.read;

	// readback source
	assign rd_word = avl.addr[regmap_pkg::ADDR_SEL_BIT] ? palette[pal_idx] : objects[obj_idx];

	// ==============================
	// storage and readback
	// ==============================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			// empty table, black palette
			for (int i = 0; i < NUM_OBJECTS; i++) begin
				objects[i] <= '0;
			end
			for (int i = 0; i < NUM_PALETTE; i++) begin
				palette[i] <= '0;
			end
			readdata <= '0;
		end else begin
			if (wr_obj) begin
				objects[obj_idx] <= merge_lanes(objects[obj_idx], avl.writedata, avl.byte_en);
			end
			if (wr_pal) begin
				palette[pal_idx] <= merge_lanes(palette[pal_idx], avl.writedata, avl.byte_en);
			end
			// read latency of one, value held until next read
			if (rd_en) begin
				readdata <= rd_word;
			end
		end
	end

	// master never issues read and write in the same selected cycle
	a_no_read_write: assert property (
		@(posedge CLK) disable iff (RESET)
		avl.cs |-> !(avl.read && avl.write)
	) else $error("avalon read and write asserted together");

endmodule

`default_nettype wire

/* source/layer_mixer.sv */
// group priority, row background, palette lookup and registered blanked colour output
`default_nettype none
`timescale 1ns/1ps

module layer_mixer #(
	parameter int NUM_PALETTE = 8
) (
	input  wire                        CLK,
	input  wire                        RESET,
	input  wire                        pix_en,
	input  wire                        blank_now,
	input  wire video_pkg::coord_t     row,
	input  wire video_pkg::layer_hit_t hit_a,
	input  wire video_pkg::layer_hit_t hit_b,
	input  wire regmap_pkg::reg_word_u palette [NUM_PALETTE],
	output video_pkg::rgb_t            rgb
);

	// background indices, both fg halves
	localparam video_pkg::color_idx_t BG_TOP_IDX    = 4'd7;
	localparam video_pkg::color_idx_t BG_BOTTOM_IDX = 4'd3;

	// stage 1 copies, line up with scanner results
	logic                       blank_q;
	video_pkg::coord_t          row_q;

	video_pkg::color_idx_t      sel_idx;
	regmap_pkg::palette_entry_t sel_entry;
	video_pkg::rgb_t            sel_rgb;

	// ==============================
	// colour select
	// ==============================

	// group a, then group b, then background
	always_comb begin
		if (hit_a.hit) begin
			sel_idx = hit_a.color;
		end else if (hit_b.hit) begin
			sel_idx = hit_b.color;
		end else if (row_q < video_pkg::BG_SPLIT_ROW) begin
			sel_idx = BG_TOP_IDX;
		end else begin
			sel_idx = BG_BOTTOM_IDX;
		end
	end

	// entry from index bits 3..1
	assign sel_entry = palette[sel_idx[3:1]].pal;
	// odd index = fg half
	assign sel_rgb   = sel_idx[0] ? sel_entry.fg : sel_entry.bg;

	// second pixel stage
	always_ff @(posedge CLK) begin
		if (RESET) begin
			blank_q <= 1'b0;
			row_q   <= '0;
			rgb     <= '0;
		end else if (pix_en) begin
			blank_q <= blank_now;
			row_q   <= row;
			// black outside the visible area
			rgb     <= blank_q ? sel_rgb : '0;
		end
	end

	// pixel blanked at the input is black once through both stages
	a_black_when_blanked: assert property (
		@(posedge CLK) disable iff (RESET)
		(pix_en && !$past(blank_now, 2)) |=> (rgb == '0)
	) else $error("colour driven during blanking");

endmodule

`default_nettype wire

/* source/object_scanner.sv */
// priority hit test of one object group against the current scan position
`default_nettype none
`timescale 1ns/1ps

module object_scanner #(
	parameter int FIRST_INDEX = 0,
	parameter int GROUP_SIZE  = 4,
	parameter int NUM_OBJECTS = 8
) (
	input  wire                       CLK,
	input  wire                       RESET,
	input  wire                       pix_en,
	input  wire video_pkg::coord_t    draw_x,
	input  wire video_pkg::coord_t    draw_y,
	input  wire regmap_pkg::reg_word_u objects [NUM_OBJECTS],
	output video_pkg::layer_hit_t     hit
);

	video_pkg::layer_hit_t hit_next;

	// square covers the pixel, visible and not empty
	function automatic logic obj_covers(
		input regmap_pkg::obj_entry_t obj,
		input video_pkg::coord_t      px,
		input video_pkg::coord_t      py
	);
		logic [10:0] size;
		logic [10:0] x_end;
		logic [10:0] y_end;
		logic        in_x;
		logic        in_y;
		// 8, 16, 32 or 64
		size  = 11'(regmap_pkg::OBJ_SIZE_BASE) << obj.kind[1:0];
		// 11 bits so x + size past 1023 does not wrap
		x_end = {1'b0, obj.x} + size;
		y_end = {1'b0, obj.y} + size;
		in_x  = (px >= obj.x) && ({1'b0, px} < x_end);
		in_y  = (py >= obj.y) && ({1'b0, py} < y_end);
		return (obj.kind != '0) && (obj.color != video_pkg::COLOR_NONE) && in_x && in_y;
	endfunction

	// walk from the top of the group down
	// lowest index is written last and wins
	always_comb begin
		hit_next = '0;
		for (int i = GROUP_SIZE - 1; i >= 0; i--) begin
			if (obj_covers(objects[FIRST_INDEX + i].obj, draw_x, draw_y)) begin
				hit_next.hit   = 1'b1;
				hit_next.color = objects[FIRST_INDEX + i].obj.color;
			end
		end
	end

	// first pixel stage
	always_ff @(posedge CLK) begin
		if (RESET) begin
			hit <= '0;
		end else if (pix_en) begin
			hit <= hit_next;
		end
	end

endmodule

`default_nettype wire

/* source/regmap_pkg.sv */
// avalon request struct, object and palette entry layouts, register word union, address map
`default_nettype none

package regmap_pkg;

	// avalon-mm slave inputs, one bundle
	typedef struct packed {
		logic        cs;
		logic        read;
		logic        write;
		logic [3:0]  byte_en;
		logic [8:0]  addr;
		logic [31:0] writedata;
	} avl_req_t;

	// object table word
	// kind 0 = empty slot, kind[1:0] = size code
	typedef struct packed {
		logic [5:0]            kind;
		video_pkg::coord_t     x;
		video_pkg::coord_t     y;
		video_pkg::color_idx_t color;
		logic [1:0]            spare;
	} obj_entry_t;

	// palette word, fg in 24..13, bg in 12..1
	typedef struct packed {
		logic [6:0]      rsvd_hi;
		video_pkg::rgb_t fg;
		video_pkg::rgb_t bg;
		logic            rsvd_lo;
	} palette_entry_t;

	// same 32-bit stored word, seen as object or palette entry
	typedef union packed {
		obj_entry_t     obj;
		palette_entry_t pal;
	} reg_word_u;

	// ==============================
	// address map
	// ==============================

	// addr[8] low = object table, high = palette
	localparam int ADDR_SEL_BIT = 8;

	// smallest object edge, size = base << kind[1:0]
	localparam int OBJ_SIZE_BASE = 8;

endpackage

`default_nettype wire

/* source/sprite_display_top.sv */
// sprite display top level with register file, timing, two scanners and layer mixer
`default_nettype none
`timescale 1ns/1ps

module sprite_display_top #(
	parameter int NUM_OBJECTS = 8,
	parameter int GROUP_SIZE  = 4,
	parameter int NUM_PALETTE = 8,
	parameter int PIPE_DEPTH  = 2
) (
	input  wire                       CLK,
	input  wire                       RESET,
	input  wire regmap_pkg::avl_req_t avl,
	output logic [31:0]               readdata,
	output logic [3:0]                red,
	output logic [3:0]                green,
	output logic [3:0]                blue,
	output logic                      hs,
	output logic                      vs,
	output logic                      blank,
	output logic                      pixel_clk
);

	regmap_pkg::reg_word_u objects [NUM_OBJECTS];
	regmap_pkg::reg_word_u palette [NUM_PALETTE];

	logic                  pix_en;
	logic                  blank_now;
	video_pkg::coord_t     draw_x;
	video_pkg::coord_t     draw_y;
	video_pkg::layer_hit_t hit_a;
	video_pkg::layer_hit_t hit_b;
	video_pkg::rgb_t       rgb;

	// ==============================
	// bus side
	// ==============================

	avalon_regs #(
		.NUM_OBJECTS(NUM_OBJECTS),
		.NUM_PALETTE(NUM_PALETTE)
	) i_avalon_regs (
		.CLK     (CLK),
		.RESET   (RESET),
		.avl     (avl),
		.readdata(readdata),
		.objects (objects),
		.palette (palette)
	);

	// ==============================
	// pixel side
	// ==============================

	vga_timing #(
		.PIPE_DEPTH(PIPE_DEPTH)
	) i_vga_timing (
		.CLK      (CLK),
		.RESET    (RESET),
		.pix_en   (pix_en),
		.draw_x   (draw_x),
		.draw_y   (draw_y),
		.blank_now(blank_now),
		.hs       (hs),
		.vs       (vs),
		.blank    (blank),
		.pixel_clk(pixel_clk)
	);

	// group 0, objects 0..3, wins in the mixer
	object_scanner #(
		.FIRST_INDEX(0),
		.GROUP_SIZE (GROUP_SIZE),
		.NUM_OBJECTS(NUM_OBJECTS)
	) i_scanner_a (
		.CLK    (CLK),
		.RESET  (RESET),
		.pix_en (pix_en),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.objects(objects),
		.hit    (hit_a)
	);

	// group 1, objects 4..7
	object_scanner #(
		.FIRST_INDEX(GROUP_SIZE),
		.GROUP_SIZE (GROUP_SIZE),
		.NUM_OBJECTS(NUM_OBJECTS)
	) i_scanner_b (
		.CLK    (CLK),
		.RESET  (RESET),
		.pix_en (pix_en),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.objects(objects),
		.hit    (hit_b)
	);

	layer_mixer #(
		.NUM_PALETTE(NUM_PALETTE)
	) i_layer_mixer (
		.CLK      (CLK),
		.RESET    (RESET),
		.pix_en   (pix_en),
		.blank_now(blank_now),
		.row      (draw_y),
		.hit_a    (hit_a),
		.hit_b    (hit_b),
		.palette  (palette),
		.rgb      (rgb)
	);

	// split colour to the dac pins
	assign red   = rgb.red;
	assign green = rgb.green;
	assign blue  = rgb.blue;

endmodule

`default_nettype wire

/* source/vga_timing.sv */
// pixel enable, scan counters, sync and blank generation with pipeline-aligned outputs
`default_nettype none
`timescale 1ns/1ps

module vga_timing #(
	parameter int PIPE_DEPTH = 2
) (
	input  wire               CLK,
	input  wire               RESET,
	output logic              pix_en,
	output video_pkg::coord_t draw_x,
	output video_pkg::coord_t draw_y,
	output logic              blank_now,
	output logic              hs,
	output logic              vs,
	output logic              blank,
	output logic              pixel_clk
);

	// sync and blank of one pixel travel together
	typedef struct packed {
		logic hs;
		logic vs;
		logic blank;
	} sync_t;

	logic  pix_phase;
	sync_t sync_now;
	sync_t sync_pipe [PIPE_DEPTH];

	// ==============================
	// pixel rate, clk / 2
	// ==============================

	// pixel_clk rises together with pix_en
	assign pix_en    = pix_phase;
	assign pixel_clk = pix_phase;

	// scan counters, draw_x / draw_y are the counters
	always_ff @(posedge CLK) begin
		if (RESET) begin
			pix_phase <= 1'b0;
			draw_x    <= '0;
			draw_y    <= '0;
		end else begin
			pix_phase <= ~pix_phase;
			if (pix_en) begin
				if (draw_x == video_pkg::coord_t'(video_pkg::H_TOTAL - 1)) begin
					draw_x <= '0;
					// end of line, step row
					if (draw_y == video_pkg::coord_t'(video_pkg::V_TOTAL - 1)) begin
						draw_y <= '0;
					end else begin
						draw_y <= draw_y + 1'b1;
					end
				end else begin
					draw_x <= draw_x + 1'b1;
				end
			end
		end
	end

	// ==============================
	// sync and blank
	// ==============================

	// active low pulses after the front porch
	assign sync_now.hs = !((draw_x >= video_pkg::H_VISIBLE + video_pkg::H_FRONT) &&
		(draw_x < video_pkg::H_VISIBLE + video_pkg::H_FRONT + video_pkg::H_SYNC));
	assign sync_now.vs = !((draw_y >= video_pkg::V_VISIBLE + video_pkg::V_FRONT) &&
		(draw_y < video_pkg::V_VISIBLE + video_pkg::V_FRONT + video_pkg::V_SYNC));
	// high = visible
	assign sync_now.blank = (draw_x < video_pkg::H_VISIBLE) && (draw_y < video_pkg::V_VISIBLE);

	assign blank_now = sync_now.blank;

	// delay to match scanner + mixer stages
	always_ff @(posedge CLK) begin
		if (RESET) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				sync_pipe[i] <= '{hs: 1'b1, vs: 1'b1, blank: 1'b0};
			end
		end else if (pix_en) begin
			sync_pipe[0] <= sync_now;
			for (int i = 1; i < PIPE_DEPTH; i++) begin
				sync_pipe[i] <= sync_pipe[i-1];
			end
		end
	end

	assign hs    = sync_pipe[PIPE_DEPTH-1].hs;
	assign vs    = sync_pipe[PIPE_DEPTH-1].vs;
	assign blank = sync_pipe[PIPE_DEPTH-1].blank;

	// counters wrap before the frame size
	a_counters_in_range: assert property (
		@(posedge CLK) disable iff (RESET)
		(draw_x < video_pkg::H_TOTAL) && (draw_y < video_pkg::V_TOTAL)
	) else $error("scan counter out of range");

endmodule

`default_nettype wire

/* source/video_pkg.sv */
// video timing constants, screen coordinate, colour index and layer result types
`default_nettype none

package video_pkg;

	// ==============================
	// 640x480 at 60 hz
	// ==============================

	// horizontal, in pixel periods
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_TOTAL   = 800;

	// vertical, in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_TOTAL   = 525;

	// background changes colour at this row
	localparam int BG_SPLIT_ROW = 240;

	// ==============================
	// pixel types
	// ==============================

	// screen coordinate, covers the full 800 x 525 scan
	typedef logic [9:0] coord_t;

	// 12-bit dac colour, red on top
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// bits 3..1 pick a palette entry, bit 0 picks fg or bg half
	typedef logic [3:0] color_idx_t;

	// transparent, never drawn
	localparam color_idx_t COLOR_NONE = 4'd15;

	// result of one object scanner for one pixel
	typedef struct packed {
		logic       hit;
		color_idx_t color;
	} layer_hit_t;

endpackage

`default_nettype wire

/* test/tb_tasks.svh */
// bus read and write, pixel sampling, value check and the directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	// ==============================
	// bus and pixel access
	// ==============================

	// one selected write cycle, then idle
	task automatic bus_write(input logic [8:0] waddr, input logic [31:0] wdata,
		input logic [3:0] wbe);
		@(posedge CLK);
		avl <= '{cs: 1'b1, read: 1'b0, write: 1'b1, byte_en: wbe, addr: waddr,
			writedata: wdata};
		@(posedge CLK);
		avl <= '0;
	endtask

	task automatic bus_read(input logic [8:0] raddr, output logic [31:0] rdata);
		@(posedge CLK);
		avl <= '{cs: 1'b1, read: 1'b1, write: 1'b0, byte_en: 4'h0, addr: raddr,
			writedata: 32'h0};
		@(posedge CLK);
		avl <= '0;
		// latency one, settled by the falling edge
		@(negedge CLK);
		rdata = readdata;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic sample_pixel(input int col, input int row, output logic [11:0] rgb);
		// let fresh register values pass the pixel pipeline
		repeat (4) @(posedge pixel_clk);
		do begin
			@(pixel_seen);
		end while (px_col != col || px_row != row);
		rgb = px_rgb;
	endtask

	task automatic check_pixel(input int col, input int row, input logic [11:0] expected);
		logic [11:0] pix;
		sample_pixel(col, row, pix);
		check_value($sformatf("rgb at (%0d,%0d)", col, row), {20'h0, pix}, {20'h0, expected});
	endtask

	// fg in 24..13, bg in 12..1
	function automatic logic [31:0] pal_word(input logic [11:0] fg, input logic [11:0] bg);
		return {7'b0, fg, bg, 1'b0};
	endfunction

	// kind, x, y, colour, two spare bits
	function automatic logic [31:0] obj_word(input logic [5:0] kind, input logic [9:0] x,
		input logic [9:0] y, input logic [3:0] color);
		return {kind, x, y, color, 2'b00};
	endfunction

	// ==============================
	// directed tests
	// ==============================

	task automatic reset_defaults();
		logic [31:0] word;
		check_value("readdata", readdata, 32'h0);
		for (int i = 0; i < 8; i++) begin
			bus_read(9'(i), word);
			check_value($sformatf("object %0d", i), word, 32'h0);
			bus_read(PAL_BASE + 9'(i), word);
			check_value($sformatf("palette %0d", i), word, 32'h0);
		end
		// black palette, black screen
		check_pixel(320, 200, 12'h000);
	endtask

	task automatic byte_lane_merge();
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] mask;
		logic [31:0] word;
		logic [3:0]  be;
		logic [8:0]  addr;
		for (int i = 0; i < 16; i++) begin
			// eight objects, then eight palette words
			addr   = (i < 8) ? 9'(i) : PAL_BASE + 9'(i - 8);
			first  = $urandom;
			second = $urandom;
			be     = 4'($urandom);
			bus_write(addr, first, 4'hf);
			bus_write(addr, second, be);
			mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
			bus_read(addr, word);
			check_value($sformatf("word at 0x%h", addr), word, (first & ~mask) | (second & mask));
		end
		// back to empty table and black palette
		for (int i = 0; i < 8; i++) begin
			bus_write(9'(i), 32'h0, 4'hf);
			bus_write(PAL_BASE + 9'(i), 32'h0, 4'hf);
		end
	endtask

	task automatic row_background();
		bus_write(PAL_BASE + 9'd1, pal_word(12'h1a2, 12'h3b4), 4'hf);
		bus_write(PAL_BASE + 9'd3, pal_word(12'h5c6, 12'h7d8), 4'hf);
		// upper half, index 7 = entry 3 fg
		check_pixel(200, 100, 12'h5c6);
		// lower half, index 3 = entry 1 fg
		check_pixel(200, 300, 12'h1a2);
	endtask

	// end of a visible line at the pins
	// black while blanked, hs low for 96 pixels after a 16 pixel front porch
	task automatic line_blanking();
		int front;
		int width;
		front = 0;
		width = 0;
		do begin
			@(posedge pixel_clk);
		end while (!blank);
		do begin
			@(posedge pixel_clk);
		end while (blank);
		// background palette is not black here
		while (hs) begin
			check_value("rgb in front porch", {20'h0, red, green, blue}, 32'h0);
			front++;
			@(posedge pixel_clk);
		end
		while (!hs) begin
			check_value("rgb in hs pulse", {20'h0, red, green, blue}, 32'h0);
			width++;
			@(posedge pixel_clk);
		end
		check_value("hs front porch", 32'(front), 32'd16);
		check_value("hs width", 32'(width), 32'd96);
	endtask

	task automatic group_priority();
		bus_write(PAL_BASE + 9'd2, pal_word(12'h9a1, 12'h2b7), 4'hf);
		bus_write(PAL_BASE + 9'd4, pal_word(12'h6f3, 12'h4e8), 4'hf);
		// group 1, 32 px at (100,50), index 9 = entry 4 fg
		bus_write(9'd5, obj_word(6'd2, 10'd100, 10'd50, 4'd9), 4'hf);
		// group 0, 16 px at (120,60), index 5 = entry 2 fg
		bus_write(9'd2, obj_word(6'd1, 10'd120, 10'd60, 4'd5), 4'hf);
		// scan order so one frame covers all
		check_pixel(110, 55, 12'h6f3);
		check_pixel(132, 55, 12'h5c6);
		check_pixel(105, 65, 12'h6f3);
		check_pixel(125, 65, 12'h9a1);
		check_pixel(136, 65, 12'h5c6);
		// below group 1 bottom edge
		check_pixel(110, 82, 12'h5c6);
	endtask

	task automatic colour_halves();
		bus_write(9'd2, 32'h0, 4'hf);
		bus_write(9'd5, 32'h0, 4'hf);
		// would show through if index 15 were drawn
		bus_write(PAL_BASE + 9'd7, pal_word(12'heee, 12'hddd), 4'hf);
		bus_write(9'd0, obj_word(6'd3, 10'd300, 10'd300, 4'd15), 4'hf);
		// empty kind with a real colour
		bus_write(9'd3, obj_word(6'd0, 10'd400, 10'd300, 4'd5), 4'hf);
		// even index 4 = entry 2 bg
		bus_write(9'd4, obj_word(6'd1, 10'd500, 10'd300, 4'd4), 4'hf);
		check_pixel(310, 310, 12'h1a2);
		check_pixel(405, 310, 12'h1a2);
		check_pixel(505, 310, 12'h2b7);
	endtask

`endif

/* test/tb_sprite_display.sv */
// testbench top with clock, reset, dut, scan position tracker, timeout and test sequence
`default_nettype none
`timescale 1ns/1ps

module tb_sprite_display;

	// one frame, 800 x 525 pixels at two clocks each
	localparam int FRAME_CYCLES   = 800 * 525 * 2;
	// four pixel tests need a frame each at worst, rest is margin
	localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES;

	// palette half of the address map
	localparam logic [8:0] PAL_BASE = 9'h100;

	logic                 CLK;
	logic                 RESET;
	regmap_pkg::avl_req_t avl;
	logic [31:0]          readdata;
	logic [3:0]           red;
	logic [3:0]           green;
	logic [3:0]           blue;
	logic                 hs;
	logic                 vs;
	logic                 blank;
	logic                 pixel_clk;

	sprite_display_top i_sprite_display_top (
		.CLK      (CLK),
		.RESET    (RESET),
		.avl      (avl),
		.readdata (readdata),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hs       (hs),
		.vs       (vs),
		.blank    (blank),
		.pixel_clk(pixel_clk)
	);

	// 100 ns period
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ==============================
	// scan position at the pins
	// ==============================

	int          col_cnt   = 0;
	int          row_cnt   = 0;
	logic        line_seen = 1'b0;
	logic        vs_q      = 1'b1;
	// last visible pixel
	int          px_col;
	int          px_row;
	logic [11:0] px_rgb;
	event        pixel_seen;

	// outputs change on the falling pixel_clk, stable at the rising one
	always @(posedge pixel_clk) begin
		// rising vs starts a new frame
		if (vs && !vs_q) begin
			row_cnt = 0;
		end
		vs_q = vs;
		if (blank) begin
			px_col    = col_cnt;
			px_row    = row_cnt;
			px_rgb    = {red, green, blue};
			col_cnt   = col_cnt + 1;
			line_seen = 1'b1;
			-> pixel_seen;
		end else if (line_seen) begin
			// first blanked pixel after a visible line
			row_cnt   = row_cnt + 1;
			col_cnt   = 0;
			line_seen = 1'b0;
		end
	end

	// ==============================
	// timeout
	// ==============================

	int cycle_count = 0;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d clock cycles, the tests did not finish", cycle_count);
			$display("sim failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	`include "tb_tasks.svh"

	// ==============================
	// test sequence
	// ==============================

	initial begin
		RESET = 1'b1;
		avl   = '0;
		void'($urandom(92049));
		// reset over four rising edges
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;
		@(posedge CLK);
		reset_defaults();
		byte_lane_merge();
		row_background();
		line_blanking();
		group_priority();
		colour_halves();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
